/* common/isa_pkg.sv */
package isa_pkg;

    // the core is a plain 32-bit machine with byte-addressed memory
    localparam int XLEN = 32;
    localparam int LANES = 4;
    localparam int BYTE_BITS = XLEN / LANES;

    typedef logic [XLEN-1:0] word_t;

    typedef logic [BYTE_BITS-1:0] byte_t;

    // bit i enables byte lane i, lane 0 being the least significant byte
    typedef logic [LANES-1:0] mask_t;

    // byte position of an access inside its word
    typedef logic [$clog2(LANES)-1:0] lane_off_t;

endpackage

/* common/mem_map_pkg.sv */
package mem_map_pkg;

    localparam int DEFAULT_DEPTH_WORDS = 128;

    // address bits that select a byte inside a word
    localparam int OFFSET_BITS = 2;

    // the memory keeps only the low index bits, so upper address bits alias
    function automatic isa_pkg::word_t word_index_of(isa_pkg::word_t addr);
        return addr >> OFFSET_BITS;
    endfunction

    function automatic isa_pkg::lane_off_t lane_offset_of(isa_pkg::word_t addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

endpackage

/* common/ram_port_if.sv */
`timescale 1ns/1ns

// one word-aligned access port, already shifted into its byte lanes
interface ram_port_if;
    import isa_pkg::*;

    word_t word_index;
    word_t wdata;
    mask_t wmask;
    logic  rd_en;
    logic  wr_en;
    word_t rdata;

    modport requester (
        output word_index, wdata, wmask, rd_en, wr_en,
        input  rdata
    );

    modport memory (
        input  word_index, wdata, wmask, rd_en, wr_en,
        output rdata
    );

endinterface

/* hw/lane_shifter.sv */
`timescale 1ns/1ns

// moves whole lanes up or down by a lane offset, filling the gap with zeros
module lane_shifter #(
    parameter type lane_t     = logic [7:0],
    parameter int  LANES      = 4,
    parameter bit  SHIFT_LEFT = 1'b1
) (
    input  lane_t [LANES-1:0]    in,
    input  isa_pkg::lane_off_t   offset,
    output lane_t [LANES-1:0]    out
);

    int shift;

    always_comb begin
        shift = int'(offset);
        for (int i = 0; i < LANES; i++) begin
            if (SHIFT_LEFT) begin
                // lanes pushed past the top are dropped
                if (i >= shift) begin
                    out[i] = in[i - shift];
                end else begin
                    out[i] = '0;
                end
            end else begin
                if (i + shift < LANES) begin
                    out[i] = in[i + shift];
                end else begin
                    out[i] = '0;
                end
            end
        end
    end

endmodule

/* data_align/data_align.sv */
`timescale 1ns/1ns

// turns a byte-addressed data request into a word access and back
module data_align (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::word_t     addr,
    input  isa_pkg::word_t     wdata,
    input  isa_pkg::mask_t     mask,
    input  logic               rd_en,
    input  logic               wr_en,
    output isa_pkg::word_t     rdata,
    ram_port_if.requester      ram
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    lane_off_t req_off;
    lane_off_t rd_off_q;
    word_t     wdata_shifted;
    mask_t     mask_shifted;

    assign req_off = lane_offset_of(addr);

    lane_shifter #(
        .lane_t    (byte_t),
        .LANES     (LANES),
        .SHIFT_LEFT(1'b1)
    ) u_wdata_shift (
        .in    (wdata),
        .offset(req_off),
        .out   (wdata_shifted)
    );

    lane_shifter #(
        .lane_t    (logic),
        .LANES     (LANES),
        .SHIFT_LEFT(1'b1)
    ) u_mask_shift (
        .in    (mask),
        .offset(req_off),
        .out   (mask_shifted)
    );

    assign ram.word_index = word_index_of(addr);
    assign ram.wdata      = wdata_shifted;
    assign ram.wmask      = mask_shifted;
    assign ram.rd_en      = rd_en;
    assign ram.wr_en      = wr_en;

    // the read word comes back a cycle later, so its offset has to wait with it
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_off_q <= '0;
        end else if (rd_en) begin
            rd_off_q <= req_off;
        end
    end

    lane_shifter #(
        .lane_t    (byte_t),
        .LANES     (LANES),
        .SHIFT_LEFT(1'b0)
    ) u_rdata_shift (
        .in    (ram.rdata),
        .offset(rd_off_q),
        .out   (rdata)
    );

    // a store must stay inside one word, so every enabled lane survives the shift
    a_store_in_word: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> $countones(mask_shifted) == $countones(mask)
    ) else $error("store mask runs past the end of the word");

endmodule

/* hw/word_ram.sv */
`timescale 1ns/1ns

// word memory with a read-only fetch port and a read/write data port
module word_ram #(
    parameter int DEPTH_WORDS = mem_map_pkg::DEFAULT_DEPTH_WORDS
) (
    input  logic           clk,
    input  logic           rst,
    input  isa_pkg::word_t fetch_index,
    input  logic           fetch_en,
    output isa_pkg::word_t fetch_word,
    ram_port_if.memory     port
);
    import isa_pkg::*;

    localparam int INDEX_BITS = $clog2(DEPTH_WORDS);

    word_t                 mem [DEPTH_WORDS];
    logic [INDEX_BITS-1:0] fetch_idx;
    logic [INDEX_BITS-1:0] data_idx;

    // only the low index bits are decoded
    assign fetch_idx = fetch_index[INDEX_BITS-1:0];
    assign data_idx  = port.word_index[INDEX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (port.wmask[b]) begin
                    mem[data_idx][b*BYTE_BITS +: BYTE_BITS] <=
                        port.wdata[b*BYTE_BITS +: BYTE_BITS];
                end
            end
        end
    end

    // reads sample the array before the write of the same edge lands
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_word <= '0;
        end else if (fetch_en) begin
            fetch_word <= mem[fetch_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port.rdata <= '0;
        end else if (port.rd_en) begin
            port.rdata <= mem[data_idx];
        end
    end

    // aliasing of upper address bits only works for a power-of-two depth
    a_depth_pow2: assert property (
        @(posedge clk) (DEPTH_WORDS & (DEPTH_WORDS - 1)) == 0
    ) else $error("memory depth is not a power of two");

endmodule

/* hw/mem_ctrl.sv */
`timescale 1ns/1ns

// memory controller of the core: instruction fetch plus aligned data access
module mem_ctrl #(
    parameter int DEPTH_WORDS = mem_map_pkg::DEFAULT_DEPTH_WORDS
) (
    input  logic           clk,
    input  logic           rst,

    input  isa_pkg::word_t fetch_addr,
    input  logic           fetch_en,
    output isa_pkg::word_t fetch_data,

    input  isa_pkg::word_t data_addr,
    input  isa_pkg::word_t data_wdata,
    input  isa_pkg::mask_t data_mask,
    input  logic           data_rd_en,
    input  logic           data_wr_en,
    output isa_pkg::word_t data_rdata
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    word_t fetch_index;

    // instruction fetches are always whole aligned words
    assign fetch_index = word_index_of(fetch_addr);

    ram_port_if u_data_port ();

    data_align u_data_align (
        .clk  (clk),
        .rst  (rst),
        .addr (data_addr),
        .wdata(data_wdata),
        .mask (data_mask),
        .rd_en(data_rd_en),
        .wr_en(data_wr_en),
        .rdata(data_rdata),
        .ram  (u_data_port.requester)
    );

    word_ram #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) u_word_ram (
        .clk        (clk),
        .rst        (rst),
        .fetch_index(fetch_index),
        .fetch_en   (fetch_en),
        .fetch_word (fetch_data),
        .port       (u_data_port.memory)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

// free-running clock and a synchronous reset held over the first rising edges
module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // the last reset edge still samples rst high
        rst <= 1'b0;
    end

endmodule

/* test/mem_ctrl_tb.sv */
`timescale 1ns/1ns

module mem_ctrl_tb;
    import isa_pkg::*;

    localparam int DEPTH_WORDS   = 128;
    localparam int RESET_TIMEOUT = 100;
    localparam int RANDOM_CYCLES = 2000;
    localparam int WATCHDOG_NS   = 100000;

    logic  clk;
    logic  rst;
    word_t fetch_addr;
    logic  fetch_en;
    word_t fetch_data;
    word_t data_addr;
    word_t data_wdata;
    mask_t data_mask;
    logic  data_rd_en;
    logic  data_wr_en;
    word_t data_rdata;

    // reference model state
    word_t model_mem [DEPTH_WORDS];
    word_t exp_fetch = '0;
    word_t exp_rdata = '0;
    int    seed = 85208;

    tb_clock_gen #(
        .PERIOD_NS   (4),
        .RESET_CYCLES(16)
    ) u_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    mem_ctrl #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .fetch_data(fetch_data),
        .data_addr (data_addr),
        .data_wdata(data_wdata),
        .data_mask (data_mask),
        .data_rd_en(data_rd_en),
        .data_wr_en(data_wr_en),
        .data_rdata(data_rdata)
    );

    function automatic word_t rand_word();
        int r;
        r = $random(seed);
        return word_t'(r);
    endfunction

    // each word gets a value spread over all of its address bits
    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [6:0] index_of(word_t addr);
        return addr[8:2];
    endfunction

    // a load returns the word moved down by its byte offset, upper lanes zero
    function automatic word_t load_view(word_t w, lane_off_t off);
        return w >> (8 * int'(off));
    endfunction

    function automatic word_t store_merge(word_t old, word_t wdata, mask_t mask, lane_off_t off);
        word_t merged;
        int    lane;
        merged = old;
        for (int b = 0; b < LANES; b++) begin
            lane = b + int'(off);
            if (mask[b] && lane < LANES) begin
                merged[lane*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // byte, halfword or word, placed so it stays inside one word
    task automatic pick_store(output mask_t mask, output lane_off_t off);
        word_t r;
        r = rand_word();
        case (r % 32'd3)
            32'd0: begin
                mask = 4'b0001;
                off  = r[9:8];
            end
            32'd1: begin
                mask = 4'b0011;
                off  = (r[9:8] == 2'd3) ? 2'd2 : r[9:8];
            end
            default: begin
                mask = 4'b1111;
                off  = 2'd0;
            end
        endcase
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // reads see the memory before the write of the same edge
    task automatic model_edge();
        if (fetch_en) begin
            exp_fetch = model_mem[index_of(fetch_addr)];
        end
        if (data_rd_en) begin
            exp_rdata = load_view(model_mem[index_of(data_addr)], data_addr[1:0]);
        end
        if (data_wr_en) begin
            model_mem[index_of(data_addr)] = store_merge(model_mem[index_of(data_addr)],
                                                         data_wdata, data_mask, data_addr[1:0]);
        end
    endtask

    // called on a falling edge, returns on the next one after checking both ports
    task automatic run_cycle(string name, logic f_en, word_t f_addr, logic r_en, logic w_en,
                             word_t d_addr, word_t d_wdata, mask_t d_mask);
        fetch_en   = f_en;
        fetch_addr = f_addr;
        data_rd_en = r_en;
        data_wr_en = w_en;
        data_addr  = d_addr;
        data_wdata = d_wdata;
        data_mask  = d_mask;
        @(posedge clk);
        model_edge();
        @(negedge clk);
        check_value({name, " fetch"}, exp_fetch, fetch_data);
        check_value({name, " load"}, exp_rdata, data_rdata);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int        waited;
        word_t     a;
        word_t     r;
        mask_t     m;
        lane_off_t off;
        fetch_addr = '0;
        fetch_en   = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_mask  = '0;
        data_rd_en = 1'b0;
        data_wr_en = 1'b0;
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            model_mem[i] = '0;
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rst !== 1'b0 && waited < RESET_TIMEOUT);
        if (rst !== 1'b0) begin
            $display("reset was never released");
            $display("TEST RESULT: FAIL");
            $fatal(1, "reset timeout");
        end

        check_value("reset fetch", '0, fetch_data);
        check_value("reset load", '0, data_rdata);

        // fill every word, then read it back through both ports
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            a = word_t'(i * 4);
            run_cycle("word_store", 1'b0, '0, 1'b0, 1'b1, a, fill_word(a), 4'b1111);
            run_cycle("word_readback", 1'b1, a, 1'b1, 1'b0, a, '0, '0);
        end

        for (int w = 0; w < 8; w++) begin
            for (int k = 0; k < 4; k++) begin
                a = word_t'(w * 4 + k);
                run_cycle("byte_store", 1'b0, '0, 1'b0, 1'b1, a, rand_word(), 4'b0001);
                run_cycle("byte_merge", 1'b1, a, 1'b1, 1'b0, word_t'(w * 4), '0, '0);
            end
            for (int k = 0; k < 3; k++) begin
                a = word_t'(w * 4 + k);
                run_cycle("half_store", 1'b0, '0, 1'b0, 1'b1, a, rand_word(), 4'b0011);
                run_cycle("half_merge", 1'b1, a, 1'b1, 1'b0, word_t'(w * 4), '0, '0);
            end
        end

        // consecutive loads never repeat the previous offset
        for (int w = 0; w < 16; w++) begin
            for (int k = 0; k < 4; k++) begin
                a = word_t'(w * 4 + (k + w) % 4);
                run_cycle("shifted_load", 1'b0, '0, 1'b1, 1'b0, a, '0, '0);
            end
        end

        for (int w = 20; w < 28; w++) begin
            pick_store(m, off);
            a = word_t'(w * 4 + int'(off));
            run_cycle("same_edge_old", 1'b1, a, 1'b1, 1'b1, a, rand_word(), m);
            run_cycle("same_edge_new", 1'b1, a, 1'b1, 1'b0, a, '0, '0);
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = rand_word();
            pick_store(m, off);
            // upper address bits stay random so aliased words get hit
            a = rand_word();
            a[1:0] = off;
            run_cycle("random_mix", r[0], rand_word(), r[1], r[2], a, rand_word(), m);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* mem_ctrl.f */
common/isa_pkg.sv
common/mem_map_pkg.sv
common/ram_port_if.sv
hw/lane_shifter.sv
data_align/data_align.sv
hw/word_ram.sv
hw/mem_ctrl.sv
test/tb_clock_gen.sv
test/mem_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module mem_ctrl_tb -f mem_ctrl.f -o mem_ctrl_sim &&
./obj_dir/mem_ctrl_sim ||
exit 1
